// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= core_tb
FILELIST  ?= core_top.f
SIM       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM) | tee /dev/stderr | grep -q "Everything OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: core_top.f
+incdir+hw
hw/core_pkg.sv
hw/core_ifu.sv
hw/core_exu.sv
hw/core_regfile.sv
hw/core_lsu.sv
hw/core_xbar.sv
hw/core_clint.sv
hw/core_top.sv
dv/core_mem.sv
dv/core_tb.sv

// File: dv/core_mem.sv
`default_nettype none

module core_mem (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        awvalid,
	output logic             awready,
	input  wire logic [31:0] awaddr,
	input  wire logic        wvalid,
	output logic             wready,
	input  wire logic [31:0] wdata,
	output logic             bvalid,
	input  wire logic        bready,
	output logic [1:0]       bresp,
	input  wire logic        arvalid,
	output logic             arready,
	input  wire logic [31:0] araddr,
	output logic             rvalid,
	input  wire logic        rready,
	output logic [31:0]      rdata,
	output logic [1:0]       rresp
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] mem [2048];
	integer      seed = 32'h43b1_1b3f;
	logic        rst_s, ar_fire, r_fire, aw_fire, w_fire, b_fire;
	logic [31:0] ar_addr_s, aw_addr_s, w_data_s;
	logic [31:0] rd_addr, wr_addr, wr_data;
	logic        rd_busy, aw_got, w_got;
	int          ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;

	function automatic int pick_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [4:0] rd);
		return {f7, rs2, rs1, 3'b000, rd, 7'h33};
	endfunction

	//////////////////////////////
	// program and data
	//////////////////////////////

	initial begin
		for (int i = 0; i < 2048; i++) begin
			mem[i] = (32'h8000_0000 + 32'(i) * 4) ^ 32'h5a5a_a5a5;
		end
		// x1 points at the data area at 0x8000_1000
		mem[0]  = {20'h80001, 5'd1, 7'h37};
		mem[1]  = {20'h12345, 5'd2, 7'h37};
		mem[2]  = enc_i(12'h678, 5'd2, 3'b000, 5'd2, 7'h13);
		mem[3]  = enc_s(12'd0, 5'd2, 5'd1);
		mem[4]  = enc_i(-12'sd5, 5'd0, 3'b000, 5'd3, 7'h13);
		mem[5]  = enc_r(7'h00, 5'd3, 5'd2, 5'd4);
		mem[6]  = enc_s(12'd4, 5'd4, 5'd1);
		mem[7]  = enc_r(7'h20, 5'd2, 5'd3, 5'd5);
		mem[8]  = enc_s(12'd8, 5'd5, 5'd1);
		// taken beq skips the store at word 10
		mem[9]  = enc_b(13'd8, 5'd3, 5'd3, 3'b000);
		mem[10] = enc_s(12'd12, 5'd2, 5'd1);
		mem[11] = enc_b(13'd8, 5'd3, 5'd3, 3'b001);
		mem[12] = enc_s(12'd16, 5'd3, 5'd1);
		mem[13] = enc_j(21'd8, 5'd6);
		mem[14] = enc_s(12'd20, 5'd2, 5'd1);
		mem[15] = enc_s(12'd24, 5'd6, 5'd1);
		mem[16] = enc_i(12'h100, 5'd1, 3'b010, 5'd7, 7'h03);
		mem[17] = enc_s(12'd28, 5'd7, 5'd1);
		// x8 + -8 hits mtime low inside the timer window
		mem[18] = {20'h0200c, 5'd8, 7'h37};
		mem[19] = enc_i(12'hff8, 5'd8, 3'b010, 5'd9, 7'h03);
		mem[20] = enc_s(12'd32, 5'd9, 5'd1);
		mem[21] = enc_i(12'hff8, 5'd8, 3'b010, 5'd10, 7'h03);
		mem[22] = enc_s(12'd36, 5'd10, 5'd1);
		mem[23] = enc_j(21'd0, 5'd0);
		mem[1088] = 32'hcafe_f00d;
	end

	initial begin
		{awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp} = '0;
		{rd_busy, aw_got, w_got} = '0;
		ar_cnt = pick_delay();
		aw_cnt = pick_delay();
		w_cnt  = pick_delay();
		b_cnt  = pick_delay();
	end

	// transfers are seen on the rising edge and answered on the falling one
	always @(posedge clock) begin
		rst_s     <= reset;
		ar_fire   <= arvalid && arready;
		r_fire    <= rvalid && rready;
		aw_fire   <= awvalid && awready;
		w_fire    <= wvalid && wready;
		b_fire    <= bvalid && bready;
		ar_addr_s <= araddr;
		aw_addr_s <= awaddr;
		w_data_s  <= wdata;
	end

	always @(negedge clock) begin
		if (rst_s) begin
			{awready, wready, bvalid, arready, rvalid} = '0;
			{rd_busy, aw_got, w_got} = '0;
		end else begin
			if (ar_fire) begin
				arready = 1'b0;
				rd_addr = ar_addr_s;
				rd_busy = 1'b1;
				r_cnt   = pick_delay();
				ar_cnt  = pick_delay();
			end else if (!rd_busy && arvalid && !arready) begin
				if (ar_cnt == 0) arready = 1'b1;
				else ar_cnt--;
			end
			if (r_fire) begin
				rvalid  = 1'b0;
				rd_busy = 1'b0;
			end else if (rd_busy && !rvalid) begin
				if (r_cnt == 0) begin
					rvalid = 1'b1;
					rdata  = mem[rd_addr[12:2]];
				end else begin
					r_cnt--;
				end
			end
			if (aw_fire) begin
				awready = 1'b0;
				aw_got  = 1'b1;
				wr_addr = aw_addr_s;
				aw_cnt  = pick_delay();
			end else if (!aw_got && awvalid && !awready) begin
				if (aw_cnt == 0) awready = 1'b1;
				else aw_cnt--;
			end
			if (w_fire) begin
				wready  = 1'b0;
				w_got   = 1'b1;
				wr_data = w_data_s;
				w_cnt   = pick_delay();
			end else if (!w_got && wvalid && !wready) begin
				if (w_cnt == 0) wready = 1'b1;
				else w_cnt--;
			end
			if (b_fire) begin
				bvalid = 1'b0;
				aw_got = 1'b0;
				w_got  = 1'b0;
				b_cnt  = pick_delay();
			end else if (aw_got && w_got && !bvalid) begin
				if (b_cnt == 0) begin
					bvalid = 1'b1;
					mem[wr_addr[12:2]] = wr_data;
				end else begin
					b_cnt--;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/core_tb.sv
`default_nettype none

`include "core_settings.svh"

module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NSTORES = 8;
	localparam int LIMIT   = 4000;

	logic        clock, reset;
	logic        awvalid, awready, wvalid, wready, bvalid, bready;
	logic        arvalid, arready, rvalid, rready;
	logic [31:0] awaddr, wdata, araddr, rdata;
	logic [1:0]  bresp, rresp;

	logic [31:0] exp_addr [NSTORES];
	logic [31:0] exp_data [NSTORES];
	// 0 exact value, 1 first timer read, 2 a later timer read
	int          exp_kind [NSTORES];
	int          aw_idx, w_idx, cycles;
	logic        ar_seen;
	logic [31:0] timer_first;

	core_top dut_i (.*);

	core_mem mem_i (.*);

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		stop_on_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, want));
	endtask

	initial begin
		exp_addr = '{32'h8000_1000, 32'h8000_1004, 32'h8000_1008, 32'h8000_1010,
			32'h8000_1018, 32'h8000_101c, 32'h8000_1020, 32'h8000_1024};
		// 0x12345678 + -5, -5 - 0x12345678, and the jal link of word 13
		exp_data = '{32'h1234_5678, 32'h1234_5673, 32'hedcb_a983, 32'hffff_fffb,
			32'h8000_0038, 32'hcafe_f00d, 32'h0, 32'h0};
		exp_kind = '{0, 0, 0, 0, 0, 0, 1, 2};
	end

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	always @(posedge clock) begin
		if (reset) begin
			aw_idx  <= 0;
			w_idx   <= 0;
			cycles  <= 0;
			ar_seen <= 1'b0;
		end else begin
			cycles <= cycles + 1;
			if (arvalid && arready) ar_seen <= 1'b1;
			if (awvalid && awready) aw_idx <= aw_idx + 1;
			if (wvalid && wready) begin
				w_idx <= w_idx + 1;
				if (exp_kind[w_idx] == 1) timer_first <= wdata;
			end
			if (aw_idx == NSTORES && w_idx == NSTORES) begin
				$display("Everything OK");
				$finish;
			end else if (cycles >= LIMIT) begin
				stop_on_error("timeout before all expected stores were seen");
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	assert property (@(posedge clock) disable iff (reset)
		arvalid && arready && !ar_seen |-> araddr == `CORE_RESET_PC)
		else report_mismatch("araddr", $sampled(araddr), `CORE_RESET_PC);

	assert property (@(posedge clock) disable iff (reset)
		awvalid && awready |-> aw_idx < NSTORES)
		else stop_on_error("a store was issued beyond the expected sequence");

	assert property (@(posedge clock) disable iff (reset)
		awvalid && awready && aw_idx < NSTORES |-> awaddr == exp_addr[aw_idx])
		else report_mismatch("awaddr", $sampled(awaddr), exp_addr[$sampled(aw_idx)]);

	assert property (@(posedge clock) disable iff (reset)
		wvalid && wready && w_idx < NSTORES && exp_kind[w_idx] == 0
		|-> wdata == exp_data[w_idx])
		else report_mismatch("wdata", $sampled(wdata), exp_data[$sampled(w_idx)]);

	// mtime only counts up, so the later read must be larger
	assert property (@(posedge clock) disable iff (reset)
		wvalid && wready && w_idx < NSTORES && exp_kind[w_idx] == 2
		|-> wdata > timer_first)
		else stop_on_error($sformatf("timer did not advance, %h after %h",
			$sampled(wdata), $sampled(timer_first)));

	// a raised valid waits for its transfer with a steady payload
	assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else stop_on_error("ar valid or address changed before its transfer");

	assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else stop_on_error("aw valid or address changed before its transfer");

	assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else stop_on_error("w valid or data changed before its transfer");

endmodule

`default_nettype wire

// File: hw/core_clint.sv
`default_nettype none

module core_clint (
	input  logic              clock,
	input  logic              reset,
	input  logic              req_valid,
	output logic              req_ready,
	input  core_pkg::rd_req_t req,
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output logic [31:0]       rsp_data
);
	logic [63:0] mtime_q;

	assign req_ready = 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime_q   <= '0;
			rsp_valid <= 1'b0;
		end else begin
			mtime_q <= mtime_q + 64'd1;
			if (rsp_valid && rsp_ready) begin
				rsp_valid <= 1'b0;
			end
			if (req_valid) begin
				rsp_valid <= 1'b1;
				// base+0xbffc has bit 2 set and returns the upper word
				rsp_data  <= req.addr[2] ? mtime_q[63:32] : mtime_q[31:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/core_exu.sv
`default_nettype none

module core_exu (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 fetch_valid,
	output logic                 fetch_ready,
	input  core_pkg::fetch_pkt_t fetch,
	output logic [3:0]           rs1,
	output logic [3:0]           rs2,
	input  logic [31:0]          rdata1,
	input  logic [31:0]          rdata2,
	output logic                 exec_valid,
	input  logic                 exec_ready,
	output core_pkg::exec_pkt_t  exec,
	input  logic                 wb_valid,
	output logic                 commit_valid,
	output core_pkg::commit_t    commit
);
	import core_pkg::*;

	inst_t       inst;
	exec_pkt_t   exec_d;
	logic [31:0] next_pc_d;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic        taken;
	logic        busy_q;

	assign inst = fetch.inst;
	assign rs1  = inst.i.rs1[3:0];
	assign rs2  = inst.s.rs2[3:0];

	//////////////////////////////
	// immediates
	//////////////////////////////

	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign imm_b = {{20{inst.s.imm_hi[6]}}, inst.s.imm_lo[0], inst.s.imm_hi[5:0],
		inst.s.imm_lo[4:1], 1'b0};
	assign imm_u = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'd0};
	assign imm_j = {{12{inst.i.imm[11]}}, inst.i.rs1, inst.i.funct3, inst.i.imm[0],
		inst.i.imm[10:1], 1'b0};

	// beq and bne differ only in funct3 bit 0
	assign taken = (inst.s.funct3[2:1] == 2'b00) &&
		((rdata1 == rdata2) != inst.s.funct3[0]);

	//////////////////////////////
	// decode and execute
	//////////////////////////////

	always_comb begin
		exec_d            = '0;
		exec_d.op         = MEM_NONE;
		exec_d.rd         = inst.i.rd[3:0];
		exec_d.store_data = rdata2;
		next_pc_d         = fetch.pc + 32'd4;
		case (inst.i.opcode)
			OPC_LUI: begin
				exec_d.reg_wen = 1'b1;
				exec_d.result  = imm_u;
			end
			OPC_OP_IMM: begin
				exec_d.reg_wen = (inst.i.funct3 == 3'b000);
				exec_d.result  = rdata1 + imm_i;
			end
			OPC_OP: begin
				// funct7 bit 5 lands on imm bit 10 of the i view
				exec_d.reg_wen = (inst.i.funct3 == 3'b000);
				exec_d.result  = inst.i.imm[10] ? rdata1 - rdata2 : rdata1 + rdata2;
			end
			OPC_LOAD: begin
				exec_d.op      = MEM_LOAD;
				exec_d.reg_wen = 1'b1;
				exec_d.result  = rdata1 + imm_i;
			end
			OPC_STORE: begin
				exec_d.op     = MEM_STORE;
				exec_d.result = rdata1 + imm_s;
			end
			OPC_JAL: begin
				exec_d.reg_wen = 1'b1;
				exec_d.result  = fetch.pc + 32'd4;
				next_pc_d      = fetch.pc + imm_j;
			end
			OPC_BRANCH: begin
				if (taken) begin
					next_pc_d = fetch.pc + imm_b;
				end
			end
			default: exec_d.reg_wen = 1'b0;
		endcase
	end

	assign fetch_ready  = !busy_q;
	assign commit_valid = wb_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q     <= 1'b0;
			exec_valid <= 1'b0;
		end else begin
			if (fetch_valid && fetch_ready) begin
				busy_q         <= 1'b1;
				exec_valid     <= 1'b1;
				exec           <= exec_d;
				commit.next_pc <= next_pc_d;
			end
			if (exec_valid && exec_ready) begin
				exec_valid <= 1'b0;
			end
			// the pc stays held until the retire strobe comes back
			if (wb_valid) begin
				busy_q <= 1'b0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		$rose(fetch_valid) |-> !busy_q);

endmodule

`default_nettype wire

// File: hw/core_ifu.sv
`default_nettype none

`include "core_settings.svh"

module core_ifu (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 commit_valid,
	input  core_pkg::commit_t    commit,
	output logic                 req_valid,
	input  logic                 req_ready,
	output core_pkg::rd_req_t    req,
	input  logic                 rsp_valid,
	output logic                 rsp_ready,
	input  logic [31:0]          rsp_data,
	output logic                 fetch_valid,
	input  logic                 fetch_ready,
	output core_pkg::fetch_pkt_t fetch
);
	typedef enum logic [1:0] {
		S_REQ,
		S_WAIT,
		S_HAND
	} state_e;

	state_e      state_q;
	logic [31:0] pc_q;

	assign req.addr  = pc_q;
	assign rsp_ready = (state_q == S_WAIT);

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q     <= S_REQ;
			pc_q        <= `CORE_RESET_PC;
			req_valid   <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			case (state_q)
				S_REQ: begin
					// out of reset the request comes up one cycle late
					req_valid <= 1'b1;
					if (req_valid && req_ready) begin
						req_valid <= 1'b0;
						state_q   <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (rsp_valid) begin
						fetch.pc    <= pc_q;
						fetch.inst  <= rsp_data;
						fetch_valid <= 1'b1;
						state_q     <= S_HAND;
					end
				end
				S_HAND: begin
					if (fetch_valid && fetch_ready) begin
						fetch_valid <= 1'b0;
					end
					// only one instruction in flight, so the next fetch waits for retire
					if (commit_valid) begin
						pc_q      <= commit.next_pc;
						req_valid <= 1'b1;
						state_q   <= S_REQ;
					end
				end
				default: state_q <= S_REQ;
			endcase
		end
	end

	// the crossbar only hands a response to the unit it granted
	assert property (@(posedge clock) disable iff (reset)
		rsp_valid |-> state_q == S_WAIT);

endmodule

`default_nettype wire

// File: hw/core_lsu.sv
`default_nettype none

module core_lsu (
	input  logic                clock,
	input  logic                reset,
	input  logic                exec_valid,
	output logic                exec_ready,
	input  core_pkg::exec_pkt_t exec,
	output logic                req_valid,
	input  logic                req_ready,
	output core_pkg::rd_req_t   req,
	input  logic                rsp_valid,
	output logic                rsp_ready,
	input  logic [31:0]         rsp_data,
	output logic                awvalid,
	input  logic                awready,
	output logic [31:0]         awaddr,
	output logic                wvalid,
	input  logic                wready,
	output logic [31:0]         wdata,
	input  logic                bvalid,
	output logic                bready,
	input  logic [1:0]          bresp,
	output logic                wb_valid,
	output logic                wb_wen,
	output logic [3:0]          wb_rd,
	output logic [31:0]         wb_data
);
	import core_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_AR,
		S_R,
		S_AW,
		S_B
	} state_e;

	state_e    state_q;
	exec_pkt_t pkt_q;
	logic      aw_done_q;
	logic      w_done_q;
	logic      aw_fire;
	logic      w_fire;

	assign exec_ready = (state_q == S_IDLE);
	assign req_valid  = (state_q == S_AR);
	assign req.addr   = pkt_q.result;
	assign rsp_ready  = (state_q == S_R);
	assign awvalid    = (state_q == S_AW) && !aw_done_q;
	assign awaddr     = pkt_q.result;
	assign wvalid     = (state_q == S_AW) && !w_done_q;
	assign wdata      = pkt_q.store_data;
	assign bready     = (state_q == S_B);
	assign aw_fire    = awvalid && awready;
	assign w_fire     = wvalid && wready;
	assign wb_wen     = pkt_q.reg_wen;
	assign wb_rd      = pkt_q.rd;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q   <= S_IDLE;
			wb_valid  <= 1'b0;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (exec_valid) begin
						pkt_q   <= exec;
						wb_data <= exec.result;
						case (exec.op)
							MEM_LOAD:  state_q <= S_AR;
							MEM_STORE: state_q <= S_AW;
							default:   wb_valid <= 1'b1;
						endcase
					end
				end
				S_AR: begin
					if (req_ready) begin
						state_q <= S_R;
					end
				end
				S_R: begin
					if (rsp_valid) begin
						wb_data  <= rsp_data;
						wb_valid <= 1'b1;
						state_q  <= S_IDLE;
					end
				end
				S_AW: begin
					// address and data may be taken in different cycles
					aw_done_q <= aw_done_q || aw_fire;
					w_done_q  <= w_done_q || w_fire;
					if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
						aw_done_q <= 1'b0;
						w_done_q  <= 1'b0;
						state_q   <= S_B;
					end
				end
				S_B: begin
					if (bvalid) begin
						wb_valid <= 1'b1;
						state_q  <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		$rose(awvalid) |-> $rose(wvalid));

	// every store is a full word to plain memory and must complete with okay
	assert property (@(posedge clock) disable iff (reset)
		bvalid && bready |-> bresp == 2'b00);

endmodule

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

	//////////////////////////////
	// instruction word
	//////////////////////////////

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_JAL    = 7'b1101111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_type_t;

	// execute pulls fields out of both views of the same word
	typedef union packed {
		i_type_t i;
		s_type_t s;
	} inst_t;

	//////////////////////////////
	// packets between units
	//////////////////////////////

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	typedef struct packed {
		logic [31:0] pc;
		inst_t       inst;
	} fetch_pkt_t;

	// result doubles as the address of a load or store
	typedef struct packed {
		mem_op_e     op;
		logic [3:0]  rd;
		logic        reg_wen;
		logic [31:0] result;
		logic [31:0] store_data;
	} exec_pkt_t;

	typedef struct packed {
		logic [31:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic [31:0] next_pc;
	} commit_t;

endpackage

`default_nettype wire

// File: hw/core_regfile.sv
`default_nettype none

`include "core_settings.svh"

module core_regfile (
	input  logic        clock,
	input  logic        reset,
	input  logic [3:0]  rs1,
	input  logic [3:0]  rs2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic        wb_valid,
	input  logic        wb_wen,
	input  logic [3:0]  wb_rd,
	input  logic [31:0] wb_data
);
	logic [31:0] regs [`CORE_NREGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid && wb_wen && wb_rd != 4'd0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// x0 is hardwired to zero
	assign rdata1 = (rs1 == 4'd0) ? 32'd0 : regs[rs1];
	assign rdata2 = (rs2 == 4'd0) ? 32'd0 : regs[rs2];

	// each instruction retires with a one-cycle strobe from load/store
	assert property (@(posedge clock) disable iff (reset)
		wb_valid |=> !wb_valid);

endmodule

`default_nettype wire

// File: hw/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// address of the first instruction fetched after reset
`define CORE_RESET_PC   32'h8000_0000
// the timer answers anywhere inside this 64 KiB window
`define CORE_CLINT_BASE 32'h0200_0000
`define CORE_CLINT_MASK 32'hffff_0000
// register count of rv32e
`define CORE_NREGS      16

`endif

// File: hw/core_top.sv
`default_nettype none

module core_top (
	input  logic        clock,
	input  logic        reset,
	output logic        awvalid,
	input  logic        awready,
	output logic [31:0] awaddr,
	output logic        wvalid,
	input  logic        wready,
	output logic [31:0] wdata,
	input  logic        bvalid,
	output logic        bready,
	input  logic [1:0]  bresp,
	output logic        arvalid,
	input  logic        arready,
	output logic [31:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp
);
	import core_pkg::*;

	fetch_pkt_t  fetch;
	exec_pkt_t   exec;
	commit_t     commit;
	rd_req_t     ifu_req;
	rd_req_t     lsu_req;
	rd_req_t     clint_req;
	logic        fetch_valid, fetch_ready, exec_valid, exec_ready, commit_valid;
	logic        wb_valid, wb_wen;
	logic [3:0]  wb_rd, rs1, rs2;
	logic [31:0] wb_data, rdata1, rdata2;
	logic        ifu_req_valid, ifu_req_ready, ifu_rsp_valid, ifu_rsp_ready;
	logic        lsu_req_valid, lsu_req_ready, lsu_rsp_valid, lsu_rsp_ready;
	logic        clint_req_valid, clint_req_ready, clint_rsp_valid, clint_rsp_ready;
	logic [31:0] ifu_rsp_data, lsu_rsp_data, clint_rsp_data;

	// units connect by matching names, the read pairs are renamed per unit
	core_ifu ifu_i (
		.*,
		.req_valid(ifu_req_valid),
		.req_ready(ifu_req_ready),
		.req(ifu_req),
		.rsp_valid(ifu_rsp_valid),
		.rsp_ready(ifu_rsp_ready),
		.rsp_data(ifu_rsp_data)
	);

	core_exu exu_i (.*);

	core_regfile regfile_i (.*);

	core_lsu lsu_i (
		.*,
		.req_valid(lsu_req_valid),
		.req_ready(lsu_req_ready),
		.req(lsu_req),
		.rsp_valid(lsu_rsp_valid),
		.rsp_ready(lsu_rsp_ready),
		.rsp_data(lsu_rsp_data)
	);

	core_xbar xbar_i (.*);

	core_clint clint_i (
		.*,
		.req_valid(clint_req_valid),
		.req_ready(clint_req_ready),
		.req(clint_req),
		.rsp_valid(clint_rsp_valid),
		.rsp_ready(clint_rsp_ready),
		.rsp_data(clint_rsp_data)
	);

endmodule

`default_nettype wire

// File: hw/core_xbar.sv
`default_nettype none

`include "core_settings.svh"

module core_xbar (
	input  logic              clock,
	input  logic              reset,
	input  logic              ifu_req_valid,
	output logic              ifu_req_ready,
	input  core_pkg::rd_req_t ifu_req,
	output logic              ifu_rsp_valid,
	input  logic              ifu_rsp_ready,
	output logic [31:0]       ifu_rsp_data,
	input  logic              lsu_req_valid,
	output logic              lsu_req_ready,
	input  core_pkg::rd_req_t lsu_req,
	output logic              lsu_rsp_valid,
	input  logic              lsu_rsp_ready,
	output logic [31:0]       lsu_rsp_data,
	output logic              clint_req_valid,
	input  logic              clint_req_ready,
	output core_pkg::rd_req_t clint_req,
	input  logic              clint_rsp_valid,
	output logic              clint_rsp_ready,
	input  logic [31:0]       clint_rsp_data,
	output logic              arvalid,
	input  logic              arready,
	output logic [31:0]       araddr,
	input  logic              rvalid,
	output logic              rready,
	input  logic [31:0]       rdata,
	input  logic [1:0]        rresp
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		X_IDLE,
		X_ADDR,
		X_DATA
	} state_e;

	state_e      state_q;
	// high while the data side owns the grant
	logic        owner_q;
	// high while the timer is the target
	logic        dest_q;
	logic        owner;
	logic        dest;
	rd_req_t     req_sel;
	logic        sel_valid;
	logic        sel_ready;
	logic        rsp_valid;
	logic        rsp_ready;
	logic [31:0] rsp_data;

	//////////////////////////////
	// address phase
	//////////////////////////////

	// in idle the grant follows the requests, data reads first
	assign owner     = (state_q == X_IDLE) ? lsu_req_valid : owner_q;
	assign req_sel   = owner ? lsu_req : ifu_req;
	assign dest      = (state_q == X_IDLE) ?
		((req_sel.addr & `CORE_CLINT_MASK) == `CORE_CLINT_BASE) : dest_q;
	assign sel_valid = (state_q != X_DATA) && (owner ? lsu_req_valid : ifu_req_valid);
	assign sel_ready = dest ? clint_req_ready : arready;

	assign arvalid         = sel_valid && !dest;
	assign araddr          = req_sel.addr;
	assign clint_req_valid = sel_valid && dest;
	assign clint_req       = req_sel;
	assign ifu_req_ready   = (state_q != X_DATA) && !owner && sel_ready;
	assign lsu_req_ready   = (state_q != X_DATA) && owner && sel_ready;

	//////////////////////////////
	// response phase
	//////////////////////////////

	assign rsp_valid       = (state_q == X_DATA) && (dest_q ? clint_rsp_valid : rvalid);
	assign rsp_data        = dest_q ? clint_rsp_data : rdata;
	assign rsp_ready       = (state_q == X_DATA) && (owner_q ? lsu_rsp_ready : ifu_rsp_ready);
	assign rready          = rsp_ready && !dest_q;
	assign clint_rsp_ready = rsp_ready && dest_q;
	assign ifu_rsp_valid   = rsp_valid && !owner_q;
	assign lsu_rsp_valid   = rsp_valid && owner_q;
	assign ifu_rsp_data    = rsp_data;
	assign lsu_rsp_data    = rsp_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= X_IDLE;
			owner_q <= 1'b0;
			dest_q  <= 1'b0;
		end else begin
			case (state_q)
				X_IDLE: begin
					if (sel_valid) begin
						owner_q <= owner;
						dest_q  <= dest;
						state_q <= sel_ready ? X_DATA : X_ADDR;
					end
				end
				X_ADDR: begin
					if (sel_valid && sel_ready) begin
						state_q <= X_DATA;
					end
				end
				X_DATA: begin
					if (rsp_valid && rsp_ready) begin
						state_q <= X_IDLE;
					end
				end
				default: state_q <= X_IDLE;
			endcase
		end
	end

	// one read outstanding means memory and timer never answer together
	assert property (@(posedge clock) disable iff (reset)
		!(rvalid && clint_rsp_valid));

	assert property (@(posedge clock) disable iff (reset)
		rvalid && rready |-> rresp == 2'b00);

endmodule

`default_nettype wire
